// ==== rtl/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ICACHE_ADDR_W   32      // fetch byte address
`define ICACHE_WORD_W   32      // one instruction, also one bus beat
`define ICACHE_LINE_W   512     // 64 byte line
`define ICACHE_SETS     64      // direct mapped
`define ICACHE_BEATS    16      // line / word

`endif

// ==== rtl/icache_pkg.sv ====
`default_nettype none
`include "icache_settings.svh"

package icache_pkg;

    // address split, derived from geometry
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_W / 8);
    localparam int INDEX_W  = $clog2(`ICACHE_SETS);
    localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
    localparam int BEAT_W   = $clog2(`ICACHE_BEATS);

    localparam logic [1:0] RESP_OKAY  = 2'b00;
    localparam logic [2:0] PROT_INSTR = 3'b100;   // unprivileged, secure, instruction

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        valid;
        fetch_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic                      valid;
        logic [`ICACHE_WORD_W-1:0] data;
        logic                      err;     // refill hit a bus error
    } fetch_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4-Lite read channels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                      arvalid;
        logic [`ICACHE_ADDR_W-1:0] araddr;
        logic [2:0]                arprot;
    } axil_ar_t;

    typedef struct packed {
        logic                      rvalid;
        logic [`ICACHE_WORD_W-1:0] rdata;
        logic [1:0]                rresp;
    } axil_r_t;

endpackage

`default_nettype wire

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module icache_data_array (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic [icache_pkg::INDEX_W-1:0] index,
    input  logic [icache_pkg::BEAT_W-1:0]  word_sel,
    input  logic                           refill,
    input  icache_pkg::line_t              refill_line,
    output logic [`ICACHE_WORD_W-1:0]      rdata
);
    import icache_pkg::*;

    line_t lines [`ICACHE_SETS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < `ICACHE_SETS; i++)
            begin
                lines[i] <= '0;
            end
        end
        else if (refill)
        begin
            lines[index] <= refill_line;    // whole line at once
        end
    end

    // word select, bits [5:2] of the byte offset
    assign rdata = lines[index][word_sel * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

`default_nettype wire

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module icache_tag_array (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic [icache_pkg::INDEX_W-1:0] index,
    input  logic [icache_pkg::TAG_W-1:0]   tag,
    input  logic                           install,
    input  logic                           flush,
    output logic                           hit
);
    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0] valid;
    logic [TAG_W-1:0]        tags [`ICACHE_SETS];

    // valid bits are control state
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
        end
        else if (flush)
        begin
            valid <= '0;                    // all sets in one cycle
        end
        else if (install)
        begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (install)
        begin
            tags[index] <= tag;
        end
    end

    assign hit = valid[index] && (tags[index] == tag);

endmodule

`default_nettype wire

// ==== rtl/refill_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module refill_buffer (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          clear,
    input  logic                          beat,
    input  logic [icache_pkg::BEAT_W-1:0] beat_idx,
    input  icache_pkg::axil_r_t           r,
    output icache_pkg::line_t             line,
    output logic                          err
);
    import icache_pkg::*;

    logic take;
    logic beat_err;
    logic err_q;

    assign take     = beat && r.rvalid;
    assign beat_err = take && (r.rresp != RESP_OKAY);

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            line[beat_idx * `ICACHE_WORD_W +: `ICACHE_WORD_W] <= r.rdata;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            err_q <= 1'b0;
        end
        else if (clear)
        begin
            err_q <= 1'b0;
        end
        else if (beat_err)
        begin
            err_q <= 1'b1;                  // sticky until next refill
        end
    end

    // current beat shows up at once so the refill can stop on it
    assign err = err_q || beat_err;

endmodule

`default_nettype wire

// ==== rtl/refill_beat_counter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module refill_beat_counter (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          start,
    input  logic                          step,
    output logic [icache_pkg::BEAT_W-1:0] count,
    output logic                          last
);
    import icache_pkg::*;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            count <= '0;
        end
        else if (start)
        begin
            count <= '0;
        end
        else if (step)
        begin
            count <= count + 1'b1;          // wraps after the final beat
        end
    end

    assign last = (count == BEAT_W'(`ICACHE_BEATS - 1));

endmodule

`default_nettype wire

// ==== rtl/icache_ctrl_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module icache_ctrl_fsm (
    input  logic                          clk,
    input  logic                          nrst,
    input  icache_pkg::fetch_req_t        req,
    output logic                          req_ready,
    output icache_pkg::fetch_rsp_t        rsp,
    input  logic                          rsp_ready,
    input  logic                          flush,
    output icache_pkg::axil_ar_t          ar,
    input  logic                          arready,
    input  logic                          rvalid,
    output logic                          rready,
    input  logic                          hit,
    input  logic [`ICACHE_WORD_W-1:0]     rdata,
    input  logic                          fill_err,
    input  logic                          beat_last,
    input  logic [icache_pkg::BEAT_W-1:0] beat_count,
    output icache_pkg::fetch_addr_t       cur_addr,
    output logic                          tag_install,
    output logic                          tag_flush,
    output logic                          data_refill,
    output logic                          buf_clear,
    output logic                          buf_beat,
    output logic                          cnt_start,
    output logic                          cnt_step
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_ADDR,
        S_DATA,
        S_INSTALL,
        S_RESP
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   accept;
    logic   miss;
    logic   beat_done;
    logic   fill_abort;

    assign accept     = req.valid && req_ready;
    assign miss       = (state == S_LOOKUP) && !hit;
    assign beat_done  = (state == S_DATA) && rvalid;
    assign fill_abort = beat_done && fill_err;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
                if (accept)
                    state_nxt = S_LOOKUP;
            S_LOOKUP:
                state_nxt = hit ? S_RESP : S_ADDR;
            S_ADDR:
                if (arready)
                    state_nxt = S_DATA;
            S_DATA:
                if (rvalid)
                begin
                    if (fill_err)
                        state_nxt = S_RESP;
                    else if (beat_last)
                        state_nxt = S_INSTALL;
                    else
                        state_nxt = S_ADDR;
                end
            S_INSTALL:
                state_nxt = S_LOOKUP;       // re-read, now hits
            S_RESP:
                if (rsp_ready)
                    state_nxt = S_IDLE;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= S_IDLE;
            rsp   <= '0;
        end
        else
        begin
            state <= state_nxt;
            if ((state == S_LOOKUP) && hit)
                rsp <= '{valid: 1'b1, data: rdata, err: 1'b0};
            else if (fill_abort)
                rsp <= '{valid: 1'b1, data: '0, err: 1'b1};
            else if ((state == S_RESP) && rsp_ready)
                rsp.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            cur_addr <= req.addr;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req_ready   = (state == S_IDLE) && !flush;     // flush wins
    assign tag_flush   = (state == S_IDLE) && flush;
    assign tag_install = (state == S_INSTALL) && !fill_err;
    assign data_refill = tag_install;
    assign buf_clear   = miss;
    assign cnt_start   = miss;
    assign buf_beat    = beat_done;
    assign cnt_step    = beat_done;
    assign rready      = (state == S_DATA);

    assign ar.arvalid = (state == S_ADDR);
    assign ar.araddr  = {cur_addr.tag, cur_addr.index, beat_count,
                         {(OFFSET_W - BEAT_W){1'b0}}};   // line base + 4k
    assign ar.arprot  = PROT_INSTR;

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module icache_top (
    input  logic                   clk,
    input  logic                   nrst,
    input  icache_pkg::fetch_req_t req,
    output logic                   req_ready,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   rsp_ready,
    input  logic                   flush,
    output icache_pkg::axil_ar_t   ar,
    input  logic                   arready,
    input  icache_pkg::axil_r_t    r,
    output logic                   rready
);
    import icache_pkg::*;

    fetch_addr_t               cur_addr;
    logic                      hit;
    logic [`ICACHE_WORD_W-1:0] word;
    logic                      fill_err;
    line_t                     fill_line;
    logic                      beat_last;
    logic [BEAT_W-1:0]         beat_count;
    logic                      tag_install;
    logic                      tag_flush;
    logic                      data_refill;
    logic                      buf_clear;
    logic                      buf_beat;
    logic                      cnt_start;
    logic                      cnt_step;

    icache_ctrl_fsm u_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .req         (req),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .flush       (flush),
        .ar          (ar),
        .arready     (arready),
        .rvalid      (r.rvalid),
        .rready      (rready),
        .hit         (hit),
        .rdata       (word),
        .fill_err    (fill_err),
        .beat_last   (beat_last),
        .beat_count  (beat_count),
        .cur_addr    (cur_addr),
        .tag_install (tag_install),
        .tag_flush   (tag_flush),
        .data_refill (data_refill),
        .buf_clear   (buf_clear),
        .buf_beat    (buf_beat),
        .cnt_start   (cnt_start),
        .cnt_step    (cnt_step)
    );

    refill_beat_counter u_beat_cnt (
        .clk   (clk),
        .nrst  (nrst),
        .start (cnt_start),
        .step  (cnt_step),
        .count (beat_count),
        .last  (beat_last)
    );

    refill_buffer u_refill_buf (
        .clk      (clk),
        .nrst     (nrst),
        .clear    (buf_clear),
        .beat     (buf_beat),
        .beat_idx (beat_count),
        .r        (r),
        .line     (fill_line),
        .err      (fill_err)
    );

    icache_tag_array u_tags (
        .clk     (clk),
        .nrst    (nrst),
        .index   (cur_addr.index),
        .tag     (cur_addr.tag),
        .install (tag_install),
        .flush   (tag_flush),
        .hit     (hit)
    );

    // word select drops the two byte bits of the offset
    icache_data_array u_data (
        .clk         (clk),
        .nrst        (nrst),
        .index       (cur_addr.index),
        .word_sel    (cur_addr.offset[OFFSET_W-1 -: BEAT_W]),
        .refill      (data_refill),
        .refill_line (fill_line),
        .rdata       (word)
    );

endmodule

`default_nettype wire

// ==== sim/axil_rom_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module axil_rom_model #(
    parameter logic [31:0] MULT    = 32'h0000_0001,
    parameter logic [31:0] PATTERN = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  icache_pkg::axil_ar_t ar,
    output logic                 arready,
    output icache_pkg::axil_r_t  r,
    input  logic                 rready,
    output logic                 stuck
);
    import icache_pkg::*;

    localparam logic [1:0] RESP_SLVERR  = 2'b10;
    localparam int         RREADY_LIMIT = 100;

    logic [31:0] addr;
    int          stall;
    int          n;

    // contents follow from the word address, nothing is stored
    function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
        return ({2'b00, byte_addr[31:2]} * MULT) ^ PATTERN;
    endfunction

    initial
    begin
        arready = 1'b0;
        r       = '0;
        stuck   = 1'b0;
        forever
        begin
            @(negedge clk);
            if (nrst && ar.arvalid)
            begin
                stall = $urandom_range(3, 0);
                repeat (stall) @(negedge clk);
                addr    = ar.araddr;
                arready = 1'b1;                     // address taken on the next edge
                @(negedge clk);
                arready = 1'b0;
                stall   = $urandom_range(3, 0);
                repeat (stall) @(negedge clk);
                r.rvalid = 1'b1;
                r.rdata  = word_at(addr);
                r.rresp  = addr[31] ? RESP_SLVERR : RESP_OKAY;   // upper half is a hole
                n = 0;
                while (!rready && n < RREADY_LIMIT)
                begin
                    @(negedge clk);
                    n++;
                end
                if (!rready)
                begin
                    $display("read data at %h was never taken by the cache", addr);
                    stuck = 1'b1;
                end
                @(negedge clk);
                r = '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_icache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "icache_settings.svh"

module tb_icache;
    import icache_pkg::*;

    localparam int          CLK_HALF     = 4;
    localparam int          WAIT_LIMIT   = 400;
    localparam int          N_RANDOM     = 500;
    localparam logic [31:0] ROM_MULT     = 32'h9E37_79B1;
    localparam logic [31:0] ROM_XOR      = 32'h5A5A_C3C3;
    localparam logic [2:0]  ARPROT_INSTR = 3'b100;      // instruction access

    logic       clk;
    logic       nrst;
    fetch_req_t req;
    logic       req_ready;
    fetch_rsp_t rsp;
    logic       rsp_ready;
    logic       flush;
    axil_ar_t   ar;
    logic       arready;
    axil_r_t    r;
    logic       rready;
    logic       rom_stuck;

    logic             ref_valid [`ICACHE_SETS];     // reference tag table
    logic [TAG_W-1:0] ref_tag   [`ICACHE_SETS];
    logic [31:0]      ar_seen   [$];                // address handshakes of one fetch
    logic             hung;
    int               n_errors;
    int               n_checks;
    int               n_hits;
    int               n_misses;
    int               n_faults;
    int               n_flushes;

    icache_top dut (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .flush     (flush),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready)
    );

    axil_rom_model #(
        .MULT    (ROM_MULT),
        .PATTERN (ROM_XOR)
    ) u_rom (
        .clk     (clk),
        .nrst    (nrst),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .stuck   (rom_stuck)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #CLK_HALF clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        if (nrst && ar.arvalid && arready)
        begin
            ar_seen.push_back(ar.araddr);
            check_value("ar.arprot", 64'(ar.arprot), 64'(ARPROT_INSTR));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] word_index;
        word_index = addr >> 2;                         // byte bits ignored
        return (word_index * ROM_MULT) ^ ROM_XOR;
    endfunction

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index,
                                              input logic [OFFSET_W-1:0] offset);
        return {tag, index, offset};
    endfunction

    // few tags over few sets, so lines keep evicting each other
    function automatic logic [31:0] random_addr();
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        case ($urandom_range(9, 0))
            0:       tag = 20'h80123;                   // error region
            1, 2, 3: tag = 20'h00ABC;
            4, 5, 6: tag = 20'h3F00F;
            default: tag = 20'h00001;
        endcase
        index  = INDEX_W'($urandom_range(7, 0) * 9);
        offset = OFFSET_W'($urandom_range(63, 0));
        return make_addr(tag, index, offset);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_ar_trace(input logic [31:0] base, input int beats);
        check_value("ar handshake count", 64'(ar_seen.size()), 64'(beats));
        for (int k = 0; k < beats && k < ar_seen.size(); k++)
            check_value("ar.araddr", 64'(ar_seen[k]), 64'(base + 32'(4 * k)));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch and flush
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fetch(input logic [31:0] addr);
        fetch_addr_t a;
        fetch_rsp_t  held;
        logic        hit_pred;
        logic        exp_err;
        int          lat;
        int          n;
        int          stall;
        a        = addr;
        hit_pred = ref_valid[a.index] && (ref_tag[a.index] == a.tag);
        exp_err  = !hit_pred && addr[31];
        if (hung)
            return;
        ar_seen.delete();
        @(negedge clk);
        req.valid = 1'b1;
        req.addr  = a;
        n = 0;
        while (!req_ready && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!req_ready)
        begin
            $display("timeout: the cache did not take the request for %h", addr);
            hung = 1'b1;
            return;
        end
        @(negedge clk);                                 // taken on the edge just passed
        req.valid = 1'b0;
        lat = 0;
        while (!rsp.valid && lat < WAIT_LIMIT)
        begin
            @(negedge clk);
            lat++;
        end
        if (!rsp.valid)
        begin
            $display("timeout: no response came for address %h", addr);
            hung = 1'b1;
            return;
        end
        if (hit_pred)
            check_value("hit latency", 64'(lat), 64'd1);
        check_value("rsp.err", 64'(rsp.err), 64'(exp_err));
        if (!exp_err)
            check_value("rsp.data", 64'(rsp.data), 64'(expected_word(addr)));
        check_ar_trace({addr[31:OFFSET_W], OFFSET_W'(0)},
                       hit_pred ? 0 : (exp_err ? 1 : `ICACHE_BEATS));
        held  = rsp;
        stall = $urandom_range(3, 0);
        for (int i = 0; i < stall; i++)
        begin
            @(negedge clk);
            check_value("rsp", 64'(rsp), 64'(held));
            check_value("req_ready", 64'(req_ready), 64'd0);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        check_value("rsp.valid", 64'(rsp.valid), 64'd0);
        if (hit_pred)
            n_hits++;
        else if (exp_err)
            n_faults++;                                 // table left as it was
        else
        begin
            n_misses++;
            ref_valid[a.index] = 1'b1;
            ref_tag[a.index]   = a.tag;
        end
    endtask

    // a hit is seen on the bus as a fetch without address handshakes
    task automatic fetch_expect(input logic [31:0] addr, input logic exp_hit);
        fetch(addr);
        if (!hung)
            check_value("cache hit", 64'(ar_seen.size() == 0), 64'(exp_hit));
    endtask

    // a request offered together with flush must be refused
    task automatic flush_cache();
        @(negedge clk);
        flush     = 1'b1;
        req.valid = 1'b1;
        req.addr  = random_addr();
        @(posedge clk);
        check_value("req_ready", 64'(req_ready), 64'd0);
        @(negedge clk);
        flush     = 1'b0;
        req.valid = 1'b0;
        for (int i = 0; i < `ICACHE_SETS; i++)
            ref_valid[i] = 1'b0;
        n_flushes++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        void'($urandom(19151));
        nrst      = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        flush     = 1'b0;
        hung      = 1'b0;
        n_errors  = 0;
        n_checks  = 0;
        n_hits    = 0;
        n_misses  = 0;
        n_faults  = 0;
        n_flushes = 0;
        for (int i = 0; i < `ICACHE_SETS; i++)
        begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        check_value("req_ready", 64'(req_ready), 64'd1);
        check_value("rsp.valid", 64'(rsp.valid), 64'd0);
        check_value("ar.arvalid", 64'(ar.arvalid), 64'd0);
        check_value("rready", 64'(rready), 64'd0);

        fetch_expect(make_addr(20'h00ABC, 6'd5, 6'h14), 1'b0);
        fetch_expect(make_addr(20'h00ABC, 6'd5, 6'h3C), 1'b1);
        fetch_expect(make_addr(20'h3F00F, 6'd5, 6'h00), 1'b0);   // same set, evicts
        fetch_expect(make_addr(20'h00ABC, 6'd5, 6'h14), 1'b0);
        fetch_expect(make_addr(20'h3F00F, 6'd9, 6'h20), 1'b0);
        flush_cache();
        fetch_expect(make_addr(20'h00ABC, 6'd5, 6'h14), 1'b0);
        fetch_expect(make_addr(20'h3F00F, 6'd9, 6'h20), 1'b0);
        fetch_expect(make_addr(20'h80123, 6'd9, 6'h04), 1'b0);   // bus error
        fetch_expect(make_addr(20'h80123, 6'd9, 6'h04), 1'b0);
        fetch_expect(make_addr(20'h3F00F, 6'd9, 6'h08), 1'b1);   // old line survives

        for (int i = 0; i < N_RANDOM && !hung; i++)
        begin
            if ($urandom_range(39, 0) == 0)
                flush_cache();
            else
                fetch(random_addr());
        end

        $display("summary: %0d hits, %0d misses, %0d bus errors, %0d flushes, %0d checks, %0d errors",
                 n_hits, n_misses, n_faults, n_flushes, n_checks, n_errors);
        if (n_errors == 0 && !hung && !rom_stuck)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_top.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_data_array.sv
rtl/icache_tag_array.sv
rtl/refill_buffer.sv
rtl/refill_beat_counter.sv
rtl/icache_ctrl_fsm.sv
rtl/icache_top.sv
sim/axil_rom_model.sv
sim/tb_icache.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing
LINTFLAGS := --lint-only --timing
TOP       := tb_icache
RTL_TOP   := icache_top
FILELIST  := icache_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := ** FAIL **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
